// ==== include/zx_settings.svh ====
// ====================
// ZX glue settings
// Bus widths, port decode values and memory map constants
// ====================
`ifndef ZX_SETTINGS_SVH
`define ZX_SETTINGS_SVH

// Bus and memory widths
`define ZX_ADDR_W       16
`define ZX_DATA_W       8
`define ZX_BANK_W       5
`define ZX_OFFSET_W     14
`define ZX_MEM_ADDR_W   19

// Memory model codes
`define ZX_MODEL_128K   2'd0
`define ZX_MODEL_48K    2'd1
`define ZX_MODEL_PLUS3  2'd2
`define ZX_MODEL_P512   2'd3

// ULA port sits on every even address
`define ZX_PORT_FE_BIT  0
// Upper nibble of the +3 paging port
`define ZX_PORT_1FFD_HI 4'b0001

// Fixed banks in normal paging
`define ZX_WIN1_BANK    5'd5
`define ZX_WIN2_BANK    5'd2
`define ZX_ROM_48K_PAGE 5'd1

// +3 special banks, window 3 in the top field
`define ZX_SPECIAL_SET0 {3'd3, 3'd2, 3'd1, 3'd0}
`define ZX_SPECIAL_SET1 {3'd7, 3'd6, 3'd5, 3'd4}
`define ZX_SPECIAL_SET2 {3'd3, 3'd6, 3'd5, 3'd4}
`define ZX_SPECIAL_SET3 {3'd3, 3'd6, 3'd7, 3'd4}

`endif

// ==== rtl/zx_pkg.sv ====
// ====================
// ZX glue types
// Paging register views shared by the paging blocks
// ====================
`include "zx_settings.svh"

package zx_pkg;

	// Named fields of the 128K paging port
	typedef struct packed {
		// Pentagon extra bank bits
		logic [1:0] ext;
		logic       lock;
		logic       rom_sel;
		// Shadow screen select, kept for the video side
		logic       screen;
		logic [2:0] ram_bank;
	} page_fields_t;

	// Same byte as written by the CPU or as decoded fields
	typedef union packed {
		logic [`ZX_DATA_W-1:0] raw;
		page_fields_t          f;
	} page_reg_u;

endpackage

// ==== rtl/cpu_bus_if.sv ====
// ====================
// Z80 bus bundle
// ====================
`timescale 1ns/1ps
`include "zx_settings.svh"

interface cpu_bus_if;

	logic [`ZX_ADDR_W-1:0] addr;
	// Data driven by the CPU
	logic [`ZX_DATA_W-1:0] dout;
	logic                  mreq_n;
	logic                  iorq_n;
	logic                  rd_n;
	logic                  wr_n;
	logic                  m1_n;

	// Strobe generation and read mux
	modport ctrl (
		input addr, dout, mreq_n, iorq_n, rd_n, wr_n, m1_n
	);

	// Register blocks only need the address and write data
	modport regs (
		input addr, dout
	);

	// Memory mapping
	modport map (
		input addr, mreq_n, rd_n, wr_n
	);

endinterface

// ==== rtl/bus_ctrl.sv ====
// ====================
// Z80 bus control
// I/O write strobe and CPU read data select
// ====================
`timescale 1ns/1ps
`include "zx_settings.svh"

module bus_ctrl (
	input  logic                  clk_sys,
	input  logic                  reset,
	cpu_bus_if.ctrl               bus,
	input  logic [`ZX_DATA_W-1:0] mem_rdata,
	input  logic [4:0]            key_data,
	input  logic                  tape_in,
	output logic                  io_wr_stb,
	output logic [`ZX_DATA_W-1:0] din
);

	logic io_wr;
	logic io_wr_q;
	logic io_rd;
	logic mem_rd_cyc;
	logic ula_sel;

	// Interrupt acknowledge has M1 low and is not an I/O access
	assign io_wr      = !bus.iorq_n && !bus.wr_n && bus.m1_n;
	assign io_rd      = !bus.iorq_n && !bus.rd_n && bus.m1_n;
	assign mem_rd_cyc = !bus.mreq_n && !bus.rd_n;
	assign ula_sel    = !bus.addr[`ZX_PORT_FE_BIT];

	// ====================
	// Write strobe
	// ====================
	// One pulse per I/O write, however long the CPU holds it
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_wr_q   <= 1'b0;
			io_wr_stb <= 1'b0;
		end else begin
			io_wr_q   <= io_wr;
			io_wr_stb <= io_wr && !io_wr_q;
		end
	end

	// ====================
	// Read data
	// ====================
	always_comb begin
		if (mem_rd_cyc) begin
			din = mem_rdata;
		end else if (io_rd && ula_sel) begin
			// Keyboard half-row in the low bits, tape level inverted on bit 6
			din = {1'b1, !tape_in, 1'b1, key_data};
		end else begin
			// Floating bus
			din = 8'hFF;
		end
	end

endmodule

// ==== rtl/paging_regs.sv ====
// ====================
// Paging registers
// 128K, +3 and Pentagon bank registers with the lock rule
// ====================
`timescale 1ns/1ps
`include "zx_settings.svh"

module paging_regs import zx_pkg::*; (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  io_wr_stb,
	cpu_bus_if.regs               bus,
	input  logic [1:0]            model,
	output page_reg_u             page_reg,
	output logic [`ZX_DATA_W-1:0] plus3_reg,
	output logic [1:0]            bank_hi,
	output logic [1:0]            model_q
);

	logic      is_48k;
	logic      is_plus3;
	logic      is_p512;
	logic      page_disable;
	logic      sel_7ffd;
	logic      sel_1ffd;
	page_reg_u wr_data;

	assign is_48k   = (model_q == `ZX_MODEL_48K);
	assign is_plus3 = (model_q == `ZX_MODEL_PLUS3);
	assign is_p512  = (model_q == `ZX_MODEL_P512);

	// Lock stays until reset, 48K has no paging at all
	assign page_disable = is_48k || page_reg.f.lock;

	// ====================
	// Port decode
	// ====================
	// 128K decodes only A15 and A1, +3 also needs A14 so 1FFD stays apart
	assign sel_7ffd = !bus.addr[15] && !bus.addr[1] && (bus.addr[14] || !is_plus3);

	assign sel_1ffd = (bus.addr[15:12] == `ZX_PORT_1FFD_HI) && !bus.addr[1] && is_plus3;

	// Written byte seen through the field view
	assign wr_data.raw = bus.dout;

	// Model is taken while reset is held
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			model_q <= model;
		end
	end

	// ====================
	// Register update
	// ====================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			page_reg  <= '0;
			plus3_reg <= '0;
			bank_hi   <= '0;
		end else if (io_wr_stb && !page_disable) begin
			if (sel_7ffd) begin
				page_reg.raw <= wr_data.raw;
				// Pentagon 512K uses the top two bits as extra bank bits
				if (is_p512) begin
					bank_hi <= wr_data.f.ext;
				end
			end else if (sel_1ffd) begin
				plus3_reg <= bus.dout;
			end
		end
	end

endmodule

// ==== rtl/mem_map.sv ====
// ====================
// Memory map
// CPU address to RAM bank or ROM page, with ROM write protect
// ====================
`timescale 1ns/1ps
`include "zx_settings.svh"

module mem_map import zx_pkg::*; (
	cpu_bus_if.map                    bus,
	input  page_reg_u                 page_reg,
	input  logic [`ZX_DATA_W-1:0]     plus3_reg,
	input  logic [1:0]                bank_hi,
	input  logic [1:0]                model_q,
	output logic [`ZX_MEM_ADDR_W-1:0] mem_addr,
	output logic                      rom_sel,
	output logic                      mem_rd,
	output logic                      mem_we
);

	logic [1:0]            window;
	logic                  special;
	logic [11:0]           special_set;
	logic [2:0]            special_bank;
	logic [`ZX_BANK_W-1:0] rom_page;
	logic [`ZX_BANK_W-1:0] bank;

	// Four 16K windows
	assign window  = bus.addr[`ZX_ADDR_W-1 -: 2];
	assign special = plus3_reg[0];

	// ====================
	// ROM page
	// ====================
	always_comb begin
		case (model_q)
			`ZX_MODEL_48K:   rom_page = `ZX_ROM_48K_PAGE;
			`ZX_MODEL_PLUS3: rom_page = {3'b000, plus3_reg[2], page_reg.f.rom_sel};
			default:         rom_page = {4'b0000, page_reg.f.rom_sel};
		endcase
	end

	// +3 all-RAM configurations
	always_comb begin
		case (plus3_reg[2:1])
			2'd0:    special_set = `ZX_SPECIAL_SET0;
			2'd1:    special_set = `ZX_SPECIAL_SET1;
			2'd2:    special_set = `ZX_SPECIAL_SET2;
			default: special_set = `ZX_SPECIAL_SET3;
		endcase
	end

	assign special_bank = special_set[3 * int'(window) +: 3];

	// ====================
	// Bank select
	// ====================
	always_comb begin
		rom_sel = 1'b0;
		if (special) begin
			bank = {{(`ZX_BANK_W - 3){1'b0}}, special_bank};
		end else begin
			case (window)
				2'd0: begin
					rom_sel = 1'b1;
					bank    = rom_page;
				end
				2'd1:    bank = `ZX_WIN1_BANK;
				2'd2:    bank = `ZX_WIN2_BANK;
				default: bank = {bank_hi, page_reg.f.ram_bank};
			endcase
		end
	end

	assign mem_addr = {bank, bus.addr[`ZX_OFFSET_W-1:0]};

	// ROM windows never see a write
	assign mem_rd = !bus.mreq_n && !bus.rd_n;
	assign mem_we = !bus.mreq_n && !bus.wr_n && !rom_sel;

endmodule

// ==== rtl/ula_port.sv ====
// ====================
// ULA port FE
// Border, EAR and MIC latches and beeper level
// ====================
`timescale 1ns/1ps
`include "zx_settings.svh"

module ula_port (
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       io_wr_stb,
	cpu_bus_if.regs    bus,
	input  logic       tape_in,
	output logic [2:0] border,
	output logic       ear,
	output logic       mic,
	output logic [7:0] audio_level
);

	logic ula_wr;

	assign ula_wr = io_wr_stb && !bus.addr[`ZX_PORT_FE_BIT];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			border <= 3'd0;
			ear    <= 1'b0;
			mic    <= 1'b0;
		end else if (ula_wr) begin
			border <= bus.dout[2:0];
			ear    <= bus.dout[4];
			mic    <= bus.dout[3];
		end
	end

	// Beeper mix, loudest source on top
	assign audio_level = {ear, mic, tape_in, 5'b00000};

endmodule

// ==== rtl/zx_glue_top.sv ====
// ====================
// ZX Spectrum CPU glue
// Bus strobes, paging, memory map and ULA port
// ====================
`timescale 1ns/1ps
`include "zx_settings.svh"

module zx_glue_top import zx_pkg::*; (
	input  logic                      clk_sys,
	input  logic                      reset,

	// Z80 bus
	input  logic [`ZX_ADDR_W-1:0]     addr,
	input  logic [`ZX_DATA_W-1:0]     dout,
	input  logic                      mreq_n,
	input  logic                      iorq_n,
	input  logic                      rd_n,
	input  logic                      wr_n,
	input  logic                      m1_n,
	output logic [`ZX_DATA_W-1:0]     din,

	// Memory request port
	input  logic [`ZX_DATA_W-1:0]     mem_rdata,
	output logic [`ZX_MEM_ADDR_W-1:0] mem_addr,
	output logic                      rom_sel,
	output logic                      mem_rd,
	output logic                      mem_we,

	// ULA and keyboard
	input  logic [4:0]                key_data,
	input  logic                      tape_in,
	output logic [2:0]                border,
	output logic                      ear,
	output logic                      mic,
	output logic [7:0]                audio_level,

	input  logic [1:0]                model
);

	cpu_bus_if bus ();

	logic                  io_wr_stb;
	page_reg_u             page_reg;
	logic [`ZX_DATA_W-1:0] plus3_reg;
	logic [1:0]            bank_hi;
	logic [1:0]            model_q;

	// ====================
	// Bus bundle
	// ====================
	assign bus.addr   = addr;
	assign bus.dout   = dout;
	assign bus.mreq_n = mreq_n;
	assign bus.iorq_n = iorq_n;
	assign bus.rd_n   = rd_n;
	assign bus.wr_n   = wr_n;
	assign bus.m1_n   = m1_n;

	// ====================
	// Blocks
	// ====================
	bus_ctrl bus_ctrl_i (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.bus       (bus.ctrl),
		.mem_rdata (mem_rdata),
		.key_data  (key_data),
		.tape_in   (tape_in),
		.io_wr_stb (io_wr_stb),
		.din       (din)
	);

	paging_regs paging_regs_i (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.io_wr_stb (io_wr_stb),
		.bus       (bus.regs),
		.model     (model),
		.page_reg  (page_reg),
		.plus3_reg (plus3_reg),
		.bank_hi   (bank_hi),
		.model_q   (model_q)
	);

	mem_map mem_map_i (
		.bus       (bus.map),
		.page_reg  (page_reg),
		.plus3_reg (plus3_reg),
		.bank_hi   (bank_hi),
		.model_q   (model_q),
		.mem_addr  (mem_addr),
		.rom_sel   (rom_sel),
		.mem_rd    (mem_rd),
		.mem_we    (mem_we)
	);

	ula_port ula_port_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.io_wr_stb   (io_wr_stb),
		.bus         (bus.regs),
		.tape_in     (tape_in),
		.border      (border),
		.ear         (ear),
		.mic         (mic),
		.audio_level (audio_level)
	);

endmodule

// ==== dv/zx_glue_props.sv ====
// ====================
// ZX glue assertions
// Strobe width, ROM write protect and paging lock
// ====================
`timescale 1ns/1ps

module zx_glue_props import zx_pkg::*; (
	input logic      clk_sys,
	input logic      reset,
	input logic      io_wr_stb,
	input logic      rom_sel,
	input logic      mem_we,
	input page_reg_u page_reg
);

	// Strobe is a single-cycle pulse
	assert property (@(posedge clk_sys) disable iff (reset) io_wr_stb |=> !io_wr_stb)
		else $error("io_wr_stb high for two cycles");

	// ROM windows are write protected
	assert property (@(posedge clk_sys) disable iff (reset) !(mem_we && rom_sel))
		else $error("mem_we high in a ROM window");

	// Locked paging stays frozen until reset
	assert property (@(posedge clk_sys) disable iff (reset)
		page_reg.f.lock |=> $stable(page_reg.raw))
		else $error("page_reg changed while locked");

endmodule

bind zx_glue_top zx_glue_props zx_glue_props_i (
	.clk_sys   (clk_sys),
	.reset     (reset),
	.io_wr_stb (io_wr_stb),
	.rom_sel   (rom_sel),
	.mem_we    (mem_we),
	.page_reg  (page_reg)
);

// ==== dv/zx_glue_tb.sv ====
// ====================
// ZX glue testbench
// Replays golden bus records and checks the DUT outputs
// ====================
`timescale 1ns/1ps
`include "zx_settings.svh"

module zx_glue_tb;

	localparam int MAX_REC = 64;

	logic                      clk_sys;
	logic                      reset;
	logic [`ZX_ADDR_W-1:0]     addr;
	logic [`ZX_DATA_W-1:0]     dout;
	logic                      mreq_n;
	logic                      iorq_n;
	logic                      rd_n;
	logic                      wr_n;
	logic                      m1_n;
	logic [`ZX_DATA_W-1:0]     din;
	logic [`ZX_DATA_W-1:0]     mem_rdata;
	logic [`ZX_MEM_ADDR_W-1:0] mem_addr;
	logic                      rom_sel;
	logic                      mem_rd;
	logic                      mem_we;
	logic [4:0]                key_data;
	logic                      tape_in;
	logic [2:0]                border;
	logic                      ear;
	logic                      mic;
	logic [7:0]                audio_level;
	logic [1:0]                model;

	// Golden rows of eleven fields
	int rec [0:MAX_REC-1][0:10];
	int n_rec;
	int start_model;
	int seed;
	bit loaded;

	zx_glue_top zx_glue_top_i (.*);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Test FAILED");
		$fatal(1, "Run stopped");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			abort_run($sformatf("Mismatch %s: expected 0x%0h, got 0x%0h", name, expected, actual));
		end
	endtask

	task automatic next_cycle();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic drive_idle();
		mreq_n = 1'b1;
		iorq_n = 1'b1;
		rd_n   = 1'b1;
		wr_n   = 1'b1;
		m1_n   = 1'b1;
	endtask

	task automatic apply_reset(input logic [1:0] m);
		reset = 1'b1;
		model = m;
		repeat (16) next_cycle();
		reset = 1'b0;
		next_cycle();
	endtask

	// ====================
	// Golden file
	// ====================
	task automatic load_golden();
		int fd;
		int cnt;
		int k;
		int f [0:10];
		string line;
		fd = $fopen("dv/zx_glue_golden.txt", "r");
		if (fd == 0) begin
			abort_run("Cannot open the golden file dv/zx_glue_golden.txt");
		end
		n_rec = 0;
		start_model = 0;
		while (!$feof(fd)) begin
			cnt = $fgets(line, fd);
			if (cnt <= 0 || line.getc(0) == "#") begin
				continue;
			end
			if ($sscanf(line, "model %h", start_model) == 1) begin
				continue;
			end
			cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2], f[3],
				f[4], f[5], f[6], f[7], f[8], f[9], f[10]);
			if (cnt == 11 && n_rec < MAX_REC) begin
				for (k = 0; k < 11; k++) begin
					rec[n_rec][k] = f[k];
				end
				n_rec++;
			end else if (cnt > 0) begin
				abort_run({"Golden line is malformed or over the record limit: ", line});
			end
		end
		$fclose(fd);
		if (n_rec == 0) begin
			abort_run("The golden file holds no records");
		end
	endtask

	// ====================
	// Record replay
	// ====================
	task automatic run_record(input int r);
		int exp_din;
		int exp_mem_rd;
		addr       = 16'(rec[r][1]);
		dout       = 8'(rec[r][2]);
		exp_din    = rec[r][3];
		// Only a memory read cycle requests a memory read
		exp_mem_rd = 0;
		case (rec[r][0])
			0: apply_reset(2'(rec[r][2]));
			1: begin
				// Registers settle two edges after the write starts
				iorq_n = 1'b0;
				wr_n   = 1'b0;
				repeat (3) next_cycle();
			end
			2: begin
				iorq_n = 1'b0;
				rd_n   = 1'b0;
				#2;
			end
			3: begin
				mem_rdata  = 8'($random(seed));
				exp_din    = int'(mem_rdata);
				exp_mem_rd = 1;
				mreq_n     = 1'b0;
				rd_n       = 1'b0;
				#2;
			end
			4: begin
				mreq_n = 1'b0;
				wr_n   = 1'b0;
				#2;
			end
			default: abort_run($sformatf("Unknown operation %0d in record %0d", rec[r][0], r));
		endcase
		check_value("din", exp_din, 32'(din));
		check_value("mem_addr", rec[r][4], 32'(mem_addr));
		check_value("rom_sel", rec[r][5], 32'(rom_sel));
		check_value("mem_rd", exp_mem_rd, 32'(mem_rd));
		check_value("mem_we", rec[r][6], 32'(mem_we));
		check_value("border", rec[r][7], 32'(border));
		check_value("ear", rec[r][8], 32'(ear));
		check_value("mic", rec[r][9], 32'(mic));
		check_value("audio_level", rec[r][10], 32'(audio_level));
		drive_idle();
		next_cycle();
	endtask

	initial begin
		int r;
		seed      = 59;
		loaded    = 1'b0;
		reset     = 1'b1;
		model     = 2'd0;
		addr      = '0;
		dout      = '0;
		mem_rdata = '0;
		// Keyboard half-row pattern, tape level high
		key_data  = 5'h15;
		tape_in   = 1'b1;
		drive_idle();
		load_golden();
		loaded = 1'b1;
		next_cycle();
		apply_reset(2'(start_model));
		for (r = 0; r < n_rec; r++) begin
			run_record(r);
		end
		$display("Test OK");
		$finish;
	end

	// Watchdog scaled by the record count
	initial begin
		wait (loaded);
		repeat (n_rec * 8 + 64) @(posedge clk_sys);
		abort_run($sformatf("Timeout after %0d cycles", n_rec * 8 + 64));
	end

endmodule

// ==== dv/zx_glue_golden.txt ====
# op addr data din mem_addr rom_sel mem_we border ear mic audio_level, all hex
# op 0 reset with model in data, 1 I/O write, 2 I/O read, 3 memory read (din from mem_rdata), 4 memory write
model 0
3 C000 00 00 00000 0 0 0 0 0 20
3 4000 00 00 14000 0 0 0 0 0 20
1 7FFD 03 FF 17FFD 0 0 0 0 0 20
3 C000 00 00 0C000 0 0 0 0 0 20
3 0000 00 00 00000 1 0 0 0 0 20
1 7FFD 24 FF 17FFD 0 0 0 0 0 20
3 C000 00 00 10000 0 0 0 0 0 20
1 7FFD 17 FF 17FFD 0 0 0 0 0 20
3 C000 00 00 10000 0 0 0 0 0 20
0 0000 01 FF 04000 1 0 0 0 0 20
1 7FFD 13 FF 17FFD 0 0 0 0 0 20
3 C000 00 00 00000 0 0 0 0 0 20
3 0000 00 00 04000 1 0 0 0 0 20
0 0000 02 FF 00000 1 0 0 0 0 20
1 1FFD 04 FF 09FFD 1 0 0 0 0 20
1 7FFD 10 FF 17FFD 0 0 0 0 0 20
3 0000 00 00 0C000 1 0 0 0 0 20
1 1FFD 01 FF 01FFD 0 0 0 0 0 20
3 4000 00 00 04000 0 0 0 0 0 20
3 8000 00 00 08000 0 0 0 0 0 20
3 C000 00 00 0C000 0 0 0 0 0 20
1 1FFD 03 FF 11FFD 0 0 0 0 0 20
3 4000 00 00 14000 0 0 0 0 0 20
3 8000 00 00 18000 0 0 0 0 0 20
3 C000 00 00 1C000 0 0 0 0 0 20
1 1FFD 05 FF 11FFD 0 0 0 0 0 20
3 C000 00 00 0C000 0 0 0 0 0 20
1 1FFD 07 FF 11FFD 0 0 0 0 0 20
3 4000 00 00 1C000 0 0 0 0 0 20
4 0000 AA FF 10000 0 1 0 0 0 20
0 0000 03 FF 00000 1 0 0 0 0 20
1 7FFD C1 FF 17FFD 0 0 0 0 0 20
3 C000 00 00 64000 0 0 0 0 0 20
4 0000 AA FF 00000 1 0 0 0 0 20
4 3FFF 55 FF 03FFF 1 0 0 0 0 20
4 8000 AA FF 08000 0 1 0 0 0 20
3 8000 00 00 08000 0 0 0 0 0 20
1 00FE 1D FF 000FE 1 0 5 1 1 E0
2 00FE 00 B5 000FE 1 0 5 1 1 E0
2 00FF 00 FF 000FF 1 0 5 1 1 E0

// ==== list.f ====
+incdir+include
rtl/zx_pkg.sv
rtl/cpu_bus_if.sv
rtl/bus_ctrl.sv
rtl/paging_regs.sv
rtl/mem_map.sv
rtl/ula_port.sv
rtl/zx_glue_top.sv
dv/zx_glue_props.sv
dv/zx_glue_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the ZX glue testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module zx_glue_tb -f list.f -o zx_glue_sim

./obj_dir/zx_glue_sim
